// File: filelist.f
source/lsu_pkg.sv
source/post_write_fifo.sv
source/lsu_req_stage.sv
source/lsu_bus_master.sv
source/lsu_top.sv
verif/tb_clkgen.sv
verif/tb_mem_slave.sv
verif/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and decide from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_top -f filelist.f -o tb_top_sim

./obj_dir/tb_top_sim > sim.log 2>&1
cat sim.log

if grep -q 'All tests passed!' sim.log; then
    echo "run_sim: PASS"
    exit 0
fi
echo "run_sim: FAIL"
exit 1

// File: source/lsu_bus_master.sv
// drains the write buffer and runs uncached reads on one single-beat bus
// a beat is an address accept on bresp_ready_i, then one bresp_data_ok_i
// reads are only requested while the write machine is idle

`timescale 1ns/1ps

module lsu_bus_master
    import lsu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fifo_empty_i,
    input  pw_entry_t         head_i,
    input  logic              rd_req_i,
    input  logic [addr_w-1:0] rd_addr_i,
    input  mem_size_t         rd_size_i,
    input  logic              bresp_ready_i,
    input  logic              bresp_data_ok_i,
    input  logic [data_w-1:0] bresp_rdata_i,
    output logic              pop_o,
    output logic              wr_idle_o,
    output logic              rd_done_o,
    output logic [data_w-1:0] rd_data_o,
    output logic              breq_valid_o,
    output logic              breq_write_o,
    output logic [addr_w-1:0] breq_addr_o,
    output mem_size_t         breq_size_o,
    output logic [strb_w-1:0] breq_strobe_o,
    output logic [data_w-1:0] breq_wdata_o
);

    typedef enum logic [1:0] {
        wr_empty,
        wr_addr,
        wr_data
    } wr_state_t;

    typedef enum logic [1:0] {
        rd_idle,
        rd_addr,
        rd_data
    } rd_state_t;

    wr_state_t wr_state_q;
    wr_state_t wr_state_d;
    rd_state_t rd_state_q;
    rd_state_t rd_state_d;
    logic      rd_active;

    // write drain machine
    always_comb begin
        wr_state_d = wr_state_q;
        pop_o      = 1'b0;
        case (wr_state_q)
            wr_empty: begin
                if (!fifo_empty_i) begin
                    pop_o      = 1'b1;
                    wr_state_d = wr_addr;
                end
            end
            wr_addr: begin
                if (bresp_ready_i) begin
                    wr_state_d = wr_data;
                end
            end
            wr_data: begin
                if (bresp_data_ok_i) begin
                    // next entry goes straight back to the address phase
                    if (!fifo_empty_i) begin
                        pop_o      = 1'b1;
                        wr_state_d = wr_addr;
                    end else begin
                        wr_state_d = wr_empty;
                    end
                end
            end
            default: begin
                wr_state_d = wr_empty;
            end
        endcase
    end

    // uncached read machine
    always_comb begin
        rd_state_d = rd_state_q;
        rd_done_o  = 1'b0;
        case (rd_state_q)
            rd_idle: begin
                if (rd_req_i) begin
                    rd_state_d = rd_addr;
                end
            end
            rd_addr: begin
                if (bresp_ready_i) begin
                    rd_state_d = rd_data;
                end
            end
            rd_data: begin
                if (bresp_data_ok_i) begin
                    rd_done_o  = 1'b1;
                    rd_state_d = rd_idle;
                end
            end
            default: begin
                rd_state_d = rd_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state_q <= wr_empty;
            rd_state_q <= rd_idle;
        end else begin
            wr_state_q <= wr_state_d;
            rd_state_q <= rd_state_d;
        end
    end

    assign rd_active = (rd_state_q != rd_idle);
    assign wr_idle_o = (wr_state_q == wr_empty);
    assign rd_data_o = bresp_rdata_i;

    // bus driven by whichever machine owns it
    assign breq_valid_o  = (wr_state_q == wr_addr) || (rd_state_q == rd_addr);
    assign breq_write_o  = !rd_active;
    assign breq_addr_o   = rd_active ? rd_addr_i : head_i.addr;
    assign breq_size_o   = rd_active ? rd_size_i : head_i.size;
    assign breq_strobe_o = rd_active ? '0 : head_i.strobe;
    assign breq_wdata_o  = head_i.data;

endmodule

// File: source/lsu_pkg.sv
// shared widths, access size encoding and the write buffer entry layout
// addresses are physical and aligned to the access size
// data is little endian, byte lane n holds address offset n

package lsu_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    // access size, matches the encoding on the memory bus
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_t;

    // one posted store, data already shifted into its byte lanes
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strobe;
        mem_size_t         size;
    } pw_entry_t;

endpackage

// File: source/lsu_req_stage.sv
// request stage: formats stores for the write buffer and runs one load at a time
// a pending load is issued only once the buffer and the write machine are idle
// a store that finds the buffer full is held here and busy_o stays high

`timescale 1ns/1ps

module lsu_req_stage
    import lsu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid_i,
    input  logic              req_write_i,
    input  mem_size_t         req_size_i,
    input  logic              req_unsigned_i,
    input  logic [addr_w-1:0] req_addr_i,
    input  logic [data_w-1:0] req_wdata_i,
    input  logic              fifo_full_i,
    input  logic              fifo_empty_i,
    input  logic              wr_idle_i,
    input  logic              rd_done_i,
    input  logic [data_w-1:0] rd_data_i,
    output logic              busy_o,
    output logic [data_w-1:0] rdata_o,
    output logic              rvalid_o,
    output logic              push_o,
    output pw_entry_t         push_entry_o,
    output logic              rd_req_o,
    output logic [addr_w-1:0] rd_addr_o,
    output mem_size_t         rd_size_o
);

    typedef enum logic [1:0] {
        ld_idle,
        ld_wait,
        ld_issue,
        ld_resp
    } ld_state_t;

    ld_state_t         ld_state_q;
    ld_state_t         ld_state_d;
    logic              accept;
    logic              drained;
    logic              push_q;
    pw_entry_t         entry_q;
    logic [strb_w-1:0] st_strobe;
    logic [data_w-1:0] st_data;
    logic [addr_w-1:0] ld_addr_q;
    mem_size_t         ld_size_q;
    logic              ld_unsigned_q;
    logic [data_w-1:0] rd_lane;
    logic [data_w-1:0] rd_ext;
    logic [data_w-1:0] rdata_q;

    assign busy_o  = (ld_state_q != ld_idle) || fifo_full_i;
    assign accept  = req_valid_i && !busy_o;
    // an in-flight push has not reached the empty flag yet
    assign drained = fifo_empty_i && wr_idle_i && !push_q;

    // store lane strobe and data shift
    always_comb begin
        case (req_size_i)
            size_byte: st_strobe = 4'b0001 << req_addr_i[1:0];
            size_half: st_strobe = 4'b0011 << {req_addr_i[1], 1'b0};
            default:   st_strobe = 4'b1111;
        endcase
        st_data = req_wdata_i << {req_addr_i[1:0], 3'b000};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            push_q <= 1'b0;
        end else if (!(push_q && fifo_full_i)) begin
            push_q <= accept && req_write_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && req_write_i) begin
            entry_q.addr   <= req_addr_i;
            entry_q.data   <= st_data;
            entry_q.strobe <= st_strobe;
            entry_q.size   <= req_size_i;
        end
    end

    // load request latch
    always_ff @(posedge clk) begin
        if (accept && !req_write_i) begin
            ld_addr_q     <= req_addr_i;
            ld_size_q     <= req_size_i;
            ld_unsigned_q <= req_unsigned_i;
        end
    end

    always_comb begin
        ld_state_d = ld_state_q;
        case (ld_state_q)
            ld_idle: begin
                if (accept && !req_write_i) begin
                    ld_state_d = ld_wait;
                end
            end
            ld_wait: begin
                if (drained) begin
                    ld_state_d = ld_issue;
                end
            end
            ld_issue: begin
                if (rd_done_i) begin
                    ld_state_d = ld_resp;
                end
            end
            default: begin
                ld_state_d = ld_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ld_state_q <= ld_idle;
        end else begin
            ld_state_q <= ld_state_d;
        end
    end

    // pick the addressed lanes and extend
    always_comb begin
        rd_lane = rd_data_i >> {ld_addr_q[1:0], 3'b000};
        case (ld_size_q)
            size_byte: rd_ext = {{24{rd_lane[7] & ~ld_unsigned_q}}, rd_lane[7:0]};
            size_half: rd_ext = {{16{rd_lane[15] & ~ld_unsigned_q}}, rd_lane[15:0]};
            default:   rd_ext = rd_lane;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ld_state_q == ld_issue && rd_done_i) begin
            rdata_q <= rd_ext;
        end
    end

    assign rdata_o      = rdata_q;
    assign rvalid_o     = (ld_state_q == ld_resp);
    assign push_o       = push_q;
    assign push_entry_o = entry_q;
    assign rd_req_o     = (ld_state_q == ld_issue);
    assign rd_addr_o    = ld_addr_q;
    assign rd_size_o    = ld_size_q;

endmodule

// File: source/lsu_top.sv
// uncached load/store unit with a posted write buffer
// loads wait until all earlier stores have left the write buffer
// the request must be held by the driver while busy_o is high
// FIFO_DEPTH must be a power of two of at least 2

`timescale 1ns/1ps

module lsu_top
    import lsu_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              req_valid_i,
    input  logic              req_write_i,
    input  mem_size_t         req_size_i,
    input  logic              req_unsigned_i,
    input  logic [addr_w-1:0] req_addr_i,
    input  logic [data_w-1:0] req_wdata_i,
    output logic              busy_o,
    output logic [data_w-1:0] rdata_o,
    output logic              rvalid_o,

    output logic              breq_valid_o,
    output logic              breq_write_o,
    output logic [addr_w-1:0] breq_addr_o,
    output mem_size_t         breq_size_o,
    output logic [strb_w-1:0] breq_strobe_o,
    output logic [data_w-1:0] breq_wdata_o,
    input  logic              bresp_ready_i,
    input  logic              bresp_data_ok_i,
    input  logic [data_w-1:0] bresp_rdata_i
);

    // request stage to write buffer
    logic              push;
    pw_entry_t         push_entry;
    logic              fifo_full;
    logic              fifo_empty;

    // write buffer to bus master
    logic              pop;
    pw_entry_t         head;
    logic              wr_idle;

    // load path
    logic              rd_req;
    logic [addr_w-1:0] rd_addr;
    mem_size_t         rd_size;
    logic              rd_done;
    logic [data_w-1:0] rd_data;

    lsu_req_stage u_req_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid_i    (req_valid_i),
        .req_write_i    (req_write_i),
        .req_size_i     (req_size_i),
        .req_unsigned_i (req_unsigned_i),
        .req_addr_i     (req_addr_i),
        .req_wdata_i    (req_wdata_i),
        .fifo_full_i    (fifo_full),
        .fifo_empty_i   (fifo_empty),
        .wr_idle_i      (wr_idle),
        .rd_done_i      (rd_done),
        .rd_data_i      (rd_data),
        .busy_o         (busy_o),
        .rdata_o        (rdata_o),
        .rvalid_o       (rvalid_o),
        .push_o         (push),
        .push_entry_o   (push_entry),
        .rd_req_o       (rd_req),
        .rd_addr_o      (rd_addr),
        .rd_size_o      (rd_size)
    );

    post_write_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_post_write_fifo (
        .clk          (clk),
        .rst_n        (rst_n),
        .push_i       (push),
        .push_entry_i (push_entry),
        .pop_i        (pop),
        .head_o       (head),
        .full_o       (fifo_full),
        .empty_o      (fifo_empty)
    );

    lsu_bus_master u_bus_master (
        .clk             (clk),
        .rst_n           (rst_n),
        .fifo_empty_i    (fifo_empty),
        .head_i          (head),
        .rd_req_i        (rd_req),
        .rd_addr_i       (rd_addr),
        .rd_size_i       (rd_size),
        .bresp_ready_i   (bresp_ready_i),
        .bresp_data_ok_i (bresp_data_ok_i),
        .bresp_rdata_i   (bresp_rdata_i),
        .pop_o           (pop),
        .wr_idle_o       (wr_idle),
        .rd_done_o       (rd_done),
        .rd_data_o       (rd_data),
        .breq_valid_o    (breq_valid_o),
        .breq_write_o    (breq_write_o),
        .breq_addr_o     (breq_addr_o),
        .breq_size_o     (breq_size_o),
        .breq_strobe_o   (breq_strobe_o),
        .breq_wdata_o    (breq_wdata_o)
    );

endmodule

// File: source/post_write_fifo.sv
// posted write buffer, a circular buffer with wrap-bit pointers
// full and empty are registered, so a push is visible one cycle later
// push while full and pop while empty are ignored

`timescale 1ns/1ps

module post_write_fifo
    import lsu_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      push_i,
    input  pw_entry_t push_entry_i,
    input  logic      pop_i,
    output pw_entry_t head_o,
    output logic      full_o,
    output logic      empty_o
);

    localparam int idx_w = $clog2(FIFO_DEPTH);
    localparam int ptr_w = idx_w + 1;

    pw_entry_t        mem_q [FIFO_DEPTH];
    pw_entry_t        head_q;
    logic [ptr_w-1:0] wptr_q;
    logic [ptr_w-1:0] rptr_q;
    logic [ptr_w-1:0] count;
    logic [ptr_w-1:0] count_next;
    logic             full_q;
    logic             empty_q;
    logic             do_push;
    logic             do_pop;

    assign do_push    = push_i && !full_q;
    assign do_pop     = pop_i && !empty_q;
    assign count      = wptr_q - rptr_q;
    // flags look ahead at this cycle's push and pop
    assign count_next = count + ptr_w'(do_push) - ptr_w'(do_pop);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            full_q  <= 1'b0;
            empty_q <= 1'b1;
        end else begin
            wptr_q  <= wptr_q + ptr_w'(do_push);
            rptr_q  <= rptr_q + ptr_w'(do_pop);
            full_q  <= (count_next == ptr_w'(FIFO_DEPTH));
            empty_q <= (count_next == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wptr_q[idx_w-1:0]] <= push_entry_i;
        end
        if (do_pop) begin
            head_q <= mem_q[rptr_q[idx_w-1:0]];
        end
    end

    assign head_o  = head_q;
    assign full_o  = full_q;
    assign empty_o = empty_q;

endmodule

// File: verif/tb_clkgen.sv
// clock and reset for the testbench
// reset is synchronous and released 1 ns after the last rising edge it covers

`timescale 1ns/1ps

module tb_clkgen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// File: verif/tb_mem_slave.sv
// single-beat bus slave over a 1 KiB byte memory, upper address bits are ignored
// address accept and data-ok each come 0 to 3 cycles late, always 3 while slow_i is high
// outputs change 1 ns after the rising edge

`timescale 1ns/1ps

module tb_mem_slave
    import lsu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              slow_i,
    input  logic              breq_valid_i,
    input  logic              breq_write_i,
    input  logic [addr_w-1:0] breq_addr_i,
    input  logic [strb_w-1:0] breq_strobe_i,
    input  logic [data_w-1:0] breq_wdata_i,
    output logic              bresp_ready_o,
    output logic              bresp_data_ok_o,
    output logic [data_w-1:0] bresp_rdata_o
);

    localparam int MEM_BYTES = 1024;

    logic [7:0] mem [MEM_BYTES];
    integer     delay_seed;

    task automatic wait_delay();
        int delay;
        int n;
        delay = slow_i ? 3 : ($random(delay_seed) & 3);
        for (n = 0; n < delay; n++) begin
            @(posedge clk);
            #1;
        end
    endtask

    // one beat: request is stable until accepted, so latch it first
    task automatic serve_beat();
        logic              wr;
        logic [9:0]        base;
        logic [strb_w-1:0] strb;
        logic [data_w-1:0] wdata;
        int                i;
        wr    = breq_write_i;
        base  = {breq_addr_i[9:2], 2'b00};
        strb  = breq_strobe_i;
        wdata = breq_wdata_i;
        wait_delay();
        bresp_ready_o = 1'b1;
        @(posedge clk);
        #1;
        bresp_ready_o = 1'b0;
        wait_delay();
        if (wr) begin
            for (i = 0; i < strb_w; i++) begin
                if (strb[i]) begin
                    mem[base + i] = wdata[8*i +: 8];
                end
            end
        end else begin
            bresp_rdata_o = {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]};
        end
        bresp_data_ok_o = 1'b1;
        @(posedge clk);
        #1;
        bresp_data_ok_o = 1'b0;
    endtask

    initial begin
        int i;
        delay_seed      = 32'h98a1_1e32;
        bresp_ready_o   = 1'b0;
        bresp_data_ok_o = 1'b0;
        bresp_rdata_o   = '0;
        // fill mixes in every address bit
        for (i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'(i * 29) ^ 8'(i >> 8) ^ 8'h5a;
        end
        forever begin
            @(posedge clk);
            #1;
            // back to back beats are served without a gap
            while (rst_n && breq_valid_i) begin
                serve_beat();
            end
        end
    end

endmodule

// File: verif/tb_top.sv
// testbench for lsu_top, directed cases then random requests against a byte array model
// the model is updated when a store is accepted; each load completes before the next request
// addresses stay inside the 1 KiB slave memory and are aligned to their size

`timescale 1ns/1ps

module tb_top
    import lsu_pkg::*;
();

    localparam int FIFO_DEPTH = 4;
    localparam int MEM_BYTES  = 1024;
    localparam int TIMEOUT    = 200;
    localparam int RAND_REQS  = 300;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    logic        req_write;
    mem_size_t   req_size;
    logic        req_unsigned;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic        busy;
    logic [31:0] rdata;
    logic        rvalid;
    logic        breq_valid;
    logic        breq_write;
    logic [31:0] breq_addr;
    mem_size_t   breq_size;
    logic [3:0]  breq_strobe;
    logic [31:0] breq_wdata;
    logic        bresp_ready;
    logic        bresp_data_ok;
    logic [31:0] bresp_rdata;
    logic        slow;

    logic [7:0]  model_mem [MEM_BYTES];
    integer      seed;
    int          errors;
    int          timeouts;
    logic        hung;

    // accepted stores in order, as they must appear on the bus
    logic [31:0] wr_addr_q [$];
    mem_size_t   wr_size_q [$];

    tb_clkgen #(
        .HALF_PERIOD  (4),
        .RESET_CYCLES (8)
    ) clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    lsu_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_valid_i     (req_valid),
        .req_write_i     (req_write),
        .req_size_i      (req_size),
        .req_unsigned_i  (req_unsigned),
        .req_addr_i      (req_addr),
        .req_wdata_i     (req_wdata),
        .busy_o          (busy),
        .rdata_o         (rdata),
        .rvalid_o        (rvalid),
        .breq_valid_o    (breq_valid),
        .breq_write_o    (breq_write),
        .breq_addr_o     (breq_addr),
        .breq_size_o     (breq_size),
        .breq_strobe_o   (breq_strobe),
        .breq_wdata_o    (breq_wdata),
        .bresp_ready_i   (bresp_ready),
        .bresp_data_ok_i (bresp_data_ok),
        .bresp_rdata_i   (bresp_rdata)
    );

    tb_mem_slave mem_slave (
        .clk             (clk),
        .rst_n           (rst_n),
        .slow_i          (slow),
        .breq_valid_i    (breq_valid),
        .breq_write_i    (breq_write),
        .breq_addr_i     (breq_addr),
        .breq_strobe_i   (breq_strobe),
        .breq_wdata_i    (breq_wdata),
        .bresp_ready_o   (bresp_ready),
        .bresp_data_ok_o (bresp_data_ok),
        .bresp_rdata_o   (bresp_rdata)
    );

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR @%0t: %s, got %08h expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_quiet_outputs(input string when_s);
        check_value({31'h0, busy}, 32'h0, {"busy_o ", when_s});
        check_value({31'h0, rvalid}, 32'h0, {"rvalid_o ", when_s});
        check_value({31'h0, breq_valid}, 32'h0, {"breq_valid_o ", when_s});
    endtask

    // every accepted bus beat carries the address and size of its request
    always @(negedge clk) begin
        if (rst_n && breq_valid && bresp_ready) begin
            if (!breq_write) begin
                check_value(breq_addr, req_addr, "bus read address");
                check_value(32'(breq_size), 32'(req_size), "bus read size");
            end else if (wr_addr_q.size() == 0) begin
                $display("bus write to %08h has no matching accepted store", breq_addr);
                errors++;
            end else begin
                check_value(breq_addr, wr_addr_q.pop_front(), "bus write address");
                check_value(32'(breq_size), 32'(wr_size_q.pop_front()), "bus write size");
            end
        end
    end

    // inputs change and outputs are read 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] align_addr(input logic [31:0] raw, input mem_size_t size);
        case (size)
            size_byte: return raw;
            size_half: return {raw[31:1], 1'b0};
            default:   return {raw[31:2], 2'b00};
        endcase
    endfunction

    // little endian: the low bytes of the store data land at addr upwards
    task automatic model_store(input mem_size_t size, input logic [31:0] addr,
                               input logic [31:0] data);
        int nbytes;
        int i;
        case (size)
            size_byte: nbytes = 1;
            size_half: nbytes = 2;
            default:   nbytes = 4;
        endcase
        for (i = 0; i < nbytes; i++) begin
            model_mem[addr[9:0] + i] = data[8*i +: 8];
        end
    endtask

    function automatic logic [31:0] expected_load(input mem_size_t size, input logic uns,
                                                  input logic [31:0] addr);
        logic [9:0]  a;
        logic [15:0] half;
        a    = addr[9:0];
        half = {model_mem[a + 1], model_mem[a]};
        case (size)
            size_byte: return uns ? {24'h0, model_mem[a]} : {{24{model_mem[a][7]}}, model_mem[a]};
            size_half: return uns ? {16'h0, half} : {{16{half[15]}}, half};
            default:   return {model_mem[a + 3], model_mem[a + 2], half};
        endcase
    endfunction

    // holds the request until busy_o is low, returns after the accepting edge
    task automatic send_request(input logic write, input mem_size_t size, input logic uns,
                                input logic [31:0] addr, input logic [31:0] wdata,
                                output int stalls);
        int cycles;
        stalls = 0;
        if (hung) begin
            return;
        end
        req_valid    = 1'b1;
        req_write    = write;
        req_size     = size;
        req_unsigned = uns;
        req_addr     = addr;
        req_wdata    = wdata;
        cycles       = 0;
        while (busy && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        stalls = cycles;
        if (busy) begin
            $display("timeout: request to %08h was not accepted within %0d cycles", addr, TIMEOUT);
            timeouts++;
            hung      = 1'b1;
            req_valid = 1'b0;
            return;
        end
        next_cycle();
        req_valid = 1'b0;
        if (write) begin
            model_store(size, addr, wdata);
            wr_addr_q.push_back(addr);
            wr_size_q.push_back(size);
        end
    endtask

    task automatic do_store(input mem_size_t size, input logic [31:0] addr,
                            input logic [31:0] data);
        int stalls;
        send_request(1'b1, size, 1'b0, addr, data, stalls);
    endtask

    task automatic load_and_check(input mem_size_t size, input logic uns,
                                  input logic [31:0] addr);
        logic [31:0] exp;
        int          cycles;
        int          stalls;
        exp = expected_load(size, uns, addr);
        send_request(1'b0, size, uns, addr, 32'h0, stalls);
        if (hung) begin
            return;
        end
        cycles = 0;
        while (!rvalid && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (!rvalid) begin
            $display("timeout: no load data from %08h within %0d cycles", addr, TIMEOUT);
            timeouts++;
            hung = 1'b1;
            return;
        end
        check_value(rdata, exp, $sformatf("load size %0d %s at %08h", size,
                    uns ? "unsigned" : "signed", addr));
    endtask

    initial begin
        int          i;
        int          k;
        int          cycles;
        int          stalls;
        int          first_stall;
        logic        stall_ok;
        logic [31:0] rnd;
        logic [31:0] addr;
        mem_size_t   size;

        seed         = 32'h98a1_1e32;
        errors       = 0;
        timeouts     = 0;
        hung         = 1'b0;
        req_valid    = 1'b0;
        req_write    = 1'b0;
        req_size     = size_word;
        req_unsigned = 1'b0;
        req_addr     = '0;
        req_wdata    = '0;
        slow         = 1'b0;

        // reset: quiet from the first edge in reset through the first cycle after it
        @(posedge clk);
        @(negedge clk);
        cycles = 0;
        while (!rst_n && cycles < TIMEOUT) begin
            check_quiet_outputs("during reset");
            @(negedge clk);
            cycles++;
        end
        if (!rst_n) begin
            $display("timeout: reset was never released");
            timeouts++;
            hung = 1'b1;
        end
        check_quiet_outputs("at reset release");
        @(negedge clk);
        check_quiet_outputs("in first cycle after reset");
        for (i = 0; i < MEM_BYTES; i++) begin
            model_mem[i] = mem_slave.mem[i];
        end
        next_cycle();

        // word store then word load
        do_store(size_word, 32'h40, 32'hdead_beef);
        load_and_check(size_word, 1'b0, 32'h40);

        // narrow stores merge into their own lanes only
        do_store(size_word, 32'h80, 32'h1122_3344);
        do_store(size_byte, 32'h81, 32'h0000_00a5);
        do_store(size_half, 32'h82, 32'h0000_c3d2);
        load_and_check(size_word, 1'b0, 32'h80);
        do_store(size_word, 32'h84, 32'h5566_7788);
        do_store(size_byte, 32'h87, 32'h0000_00e1);
        do_store(size_half, 32'h84, 32'h0000_9f0a);
        load_and_check(size_word, 1'b0, 32'h84);

        // sign and zero extension, bytes 81 7f ff 80
        do_store(size_word, 32'hc0, 32'h80ff_7f81);
        for (k = 0; k < 4; k++) begin
            load_and_check(size_byte, 1'b0, 32'hc0 + 32'(k));
            load_and_check(size_byte, 1'b1, 32'hc0 + 32'(k));
        end
        load_and_check(size_half, 1'b0, 32'hc0);
        load_and_check(size_half, 1'b1, 32'hc0);
        load_and_check(size_half, 1'b0, 32'hc2);
        load_and_check(size_half, 1'b1, 32'hc2);

        // back-pressure with the slave at its slowest
        slow        = 1'b1;
        first_stall = -1;
        for (k = 0; k < 8; k++) begin
            rnd = $random(seed);
            send_request(1'b1, size_word, 1'b0, 32'h100 + 32'(4 * k), rnd, stalls);
            if (stalls > 0 && first_stall < 0) begin
                first_stall = k;
            end
        end
        // buffer entries, the popped head and one held push absorb the burst
        stall_ok = (first_stall >= 0) && (first_stall <= FIFO_DEPTH + 2);
        check_value({31'h0, stall_ok}, 32'h1, "busy_o rise during store burst");
        slow = 1'b0;
        for (k = 0; k < 8; k++) begin
            load_and_check(size_word, 1'b0, 32'h100 + 32'(4 * k));
        end

        // random mix in a small window so loads hit recent stores
        for (k = 0; k < RAND_REQS; k++) begin
            rnd = $random(seed);
            case (rnd[3:2])
                2'd0:    size = size_byte;
                2'd1:    size = size_half;
                default: size = size_word;
            endcase
            addr = align_addr({26'h0, rnd[9:4]}, size);
            if (rnd[0]) begin
                do_store(size, addr, $random(seed));
            end else begin
                load_and_check(size, rnd[1], addr);
            end
        end

        $display("summary: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
